/* source/cpu_pkg.sv */
package cpu_pkg;

	////////////////////
	// Instruction set
	////////////////////

	// Codes 7, 13 and 14 are spare and behave as NOP
	typedef enum logic [3:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_nor = 4'd3,
		op_sll = 4'd4,
		op_srl = 4'd5,
		op_sra = 4'd6,
		op_lw  = 4'd8,
		op_sw  = 4'd9,
		op_llb = 4'd10,
		op_lhb = 4'd11,
		op_b   = 4'd12,
		op_hlt = 4'd15
	} opcode_e;

	// Branch conditions on N, Z, V
	typedef enum logic [2:0] {
		cond_ne = 3'd0,
		cond_eq = 3'd1,
		cond_gt = 3'd2,
		cond_lt = 3'd3,
		cond_ge = 3'd4,
		cond_le = 3'd5,
		cond_ov = 3'd6,
		cond_un = 3'd7
	} cond_e;

	// Register form, rt doubles as shift amount or word offset
	typedef struct packed {
		opcode_e    opcode;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] rt;
	} instr_r_t;

	// Branch form; LLB/LHB use offset[7:0] as imm8
	typedef struct packed {
		opcode_e    opcode;
		cond_e      cond;
		logic [8:0] offset;
	} instr_b_t;

	typedef union packed {
		instr_r_t r;
		instr_b_t b;
	} instr_u;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	////////////////////
	// Pipeline registers
	////////////////////

	typedef struct packed {
		logic        valid;
		opcode_e     opcode;
		logic [3:0]  rd;
		logic [15:0] op_a;
		logic [15:0] op_b;
		// Shift amount, or signed word offset for LW/SW
		logic [3:0]  shamt;
		logic [7:0]  imm8;
		logic [15:0] st_data;
	} id_ex_t;

	typedef struct packed {
		logic        valid;
		logic [3:0]  rd;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		// ALU result or data address
		logic [15:0] result;
		logic [15:0] st_data;
	} ex_mem_t;

	// Register write, also the observation strobe
	typedef struct packed {
		logic        valid;
		logic [3:0]  rd;
		logic [15:0] data;
	} wb_port_t;

	typedef struct packed {
		logic        valid;
		logic [15:0] addr;
		logic [15:0] data;
	} mem_wr_t;

	// Ops that end with a register write
	function automatic logic writes_rd(opcode_e op);
		case (op)
			op_add, op_sub, op_and, op_nor, op_sll, op_srl, op_sra,
			op_lw, op_llb, op_lhb: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

endpackage

/* source/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage (
	input  logic        clk,
	input  logic        arst_n,
	input  logic        hold,
	input  logic        redirect,
	input  logic [15:0] target,
	input  logic        halt,
	output logic [15:0] imem_addr,
	output logic [15:0] if_pc,
	output logic        if_valid
);

	// Address requested this cycle when not held
	logic [15:0] pc_q;
	// Sticky once HLT has been seen in decode
	logic        halted_q;

	// Held slot asks for its own word once more
	assign imem_addr = hold ? if_pc : pc_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q     <= '0;
			if_pc    <= '0;
			if_valid <= 1'b0;
			halted_q <= 1'b0;
		end else if (halt || halted_q) begin
			// PC frozen, nothing more reaches decode
			halted_q <= 1'b1;
			if_valid <= 1'b0;
		end else if (redirect) begin
			// Word already in flight is killed
			pc_q     <= target;
			if_valid <= 1'b0;
		end else if (!hold) begin
			pc_q     <= pc_q + 16'd1;
			// ROM returns this word next cycle
			if_pc    <= pc_q;
			if_valid <= 1'b1;
		end
	end

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::instr_u   instr,
	input  logic [15:0]       if_pc,
	input  logic              if_valid,
	input  cpu_pkg::flags_t   flags,
	input  logic              flag_pending,
	input  cpu_pkg::ex_mem_t  ex_q,
	input  cpu_pkg::wb_port_t wb_q,
	output logic [3:0]        rd_addr0,
	output logic [3:0]        rd_addr1,
	input  logic [15:0]       rd_data0,
	input  logic [15:0]       rd_data1,
	output logic              hold,
	output logic              redirect,
	output logic [15:0]       target,
	output logic              halt,
	output cpu_pkg::id_ex_t   id_q
);
	import cpu_pkg::*;

	opcode_e op;
	// Source operand actually read by this op
	logic    use0;
	logic    use1;
	logic    raw;
	logic    is_branch;
	logic    taken;
	id_ex_t  id_d;

	// Any older write still in flight to r
	function automatic logic pending_write(logic [3:0] r);
		logic hit_ex;
		logic hit_mem;
		logic hit_wb;
		hit_ex  = id_q.valid && writes_rd(id_q.opcode) && (id_q.rd == r);
		hit_mem = ex_q.valid && ex_q.reg_write && (ex_q.rd == r);
		hit_wb  = wb_q.valid && (wb_q.rd == r);
		// R0 never carries a dependency
		return (r != 4'd0) && (hit_ex || hit_mem || hit_wb);
	endfunction

	function automatic logic cond_met(cond_e c, flags_t f);
		case (c)
			cond_ne: return !f.z;
			cond_eq: return f.z;
			cond_gt: return !f.z && !f.n;
			cond_lt: return f.n;
			cond_ge: return !f.n;
			cond_le: return f.n || f.z;
			cond_ov: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	////////////////////
	// Decode and interlock
	////////////////////

	always_comb begin
		op = instr.r.opcode;

		// LHB keeps the low byte of rd; SW stores rd
		rd_addr0 = (op == op_lhb) ? instr.r.rd : instr.r.rs;
		rd_addr1 = (op == op_sw) ? instr.r.rd : instr.r.rt;

		use0 = op inside {op_add, op_sub, op_and, op_nor, op_sll, op_srl, op_sra,
			op_lw, op_sw, op_lhb};
		use1 = op inside {op_add, op_sub, op_and, op_nor, op_sw};

		raw = (use0 && pending_write(rd_addr0)) || (use1 && pending_write(rd_addr1));

		// Branch waits for flags from an ALU op in execute
		is_branch = (op == op_b);
		taken     = cond_met(instr.b.cond, flags);

		hold     = if_valid && (raw || (is_branch && flag_pending));
		redirect = if_valid && is_branch && !flag_pending && taken;
		// Relative to the word after the branch
		target   = if_pc + 16'd1 + {{7{instr.b.offset[8]}}, instr.b.offset};
		halt     = if_valid && (op == op_hlt);
	end

	// Held or killed slot leaves a bubble
	always_comb begin
		id_d.valid   = if_valid && !hold;
		id_d.opcode  = op;
		id_d.rd      = instr.r.rd;
		id_d.op_a    = rd_data0;
		id_d.op_b    = rd_data1;
		id_d.shamt   = instr.r.rt;
		id_d.imm8    = instr.b.offset[7:0];
		id_d.st_data = rd_data1;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_q <= '0;
		end else begin
			id_q <= id_d;
		end
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              arst_n,
	input  logic [3:0]        rd_addr0,
	input  logic [3:0]        rd_addr1,
	output logic [15:0]       rd_data0,
	output logic [15:0]       rd_data1,
	input  cpu_pkg::wb_port_t wr
);

	logic [15:0] regs [16];

	// R0 reads zero; same-cycle write is passed through
	function automatic logic [15:0] read_port(logic [3:0] a);
		if (a == 4'd0)
			return '0;
		if (wr.valid && (wr.rd == a))
			return wr.data;
		return regs[a];
	endfunction

	always_comb begin
		rd_data0 = read_port(rd_addr0);
		rd_data1 = read_port(rd_addr1);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr.valid && (wr.rd != 4'd0)) begin
			regs[wr.rd] <= wr.data;
		end
	end

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  cpu_pkg::id_ex_t  id_q,
	output cpu_pkg::flags_t  flags,
	output logic             flag_pending,
	output cpu_pkg::ex_mem_t ex_q
);
	import cpu_pkg::*;

	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] result;
	// Signed overflow, only ADD/SUB raise it
	logic        ovf;
	logic        alu_op;
	ex_mem_t     ex_d;

	assign a = id_q.op_a;
	assign b = id_q.op_b;

	assign alu_op       = id_q.opcode inside {op_add, op_sub, op_and, op_nor,
		op_sll, op_srl, op_sra};
	// Flags land at the end of this cycle
	assign flag_pending = id_q.valid && alu_op;

	always_comb begin
		ovf = 1'b0;
		case (id_q.opcode)
			op_add: begin
				result = a + b;
				ovf    = (a[15] == b[15]) && (result[15] != a[15]);
			end
			op_sub: begin
				result = a - b;
				ovf    = (a[15] != b[15]) && (result[15] != a[15]);
			end
			op_and: result = a & b;
			op_nor: result = ~(a | b);
			op_sll: result = a << id_q.shamt;
			op_srl: result = a >> id_q.shamt;
			op_sra: result = $signed(a) >>> id_q.shamt;
			// Word address, rs plus signed offset
			op_lw, op_sw: result = a + {{12{id_q.shamt[3]}}, id_q.shamt};
			op_llb: result = {{8{id_q.imm8[7]}}, id_q.imm8};
			// High byte replaced, low byte of rd kept
			op_lhb: result = {id_q.imm8, a[7:0]};
			default: result = '0;
		endcase
	end

	always_comb begin
		ex_d.valid     = id_q.valid;
		ex_d.rd        = id_q.rd;
		ex_d.reg_write = id_q.valid && writes_rd(id_q.opcode) && (id_q.rd != 4'd0);
		ex_d.mem_read  = id_q.valid && (id_q.opcode == op_lw);
		ex_d.mem_write = id_q.valid && (id_q.opcode == op_sw);
		ex_d.result    = result;
		ex_d.st_data   = id_q.st_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags <= '0;
			ex_q  <= '0;
		end else begin
			if (flag_pending) begin
				flags.n <= result[15];
				flags.z <= (result == 16'd0);
				flags.v <= ovf;
			end
			ex_q <= ex_d;
		end
	end

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage #(
	parameter int dmem_depth = 64
) (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::ex_mem_t  ex_q,
	output cpu_pkg::wb_port_t wb,
	output cpu_pkg::mem_wr_t  st,
	input  logic              halt_in,
	output logic              hlt
);
	import cpu_pkg::*;

	localparam int addr_w = $clog2(dmem_depth);

	logic [15:0]       mem [dmem_depth];
	// Address wraps modulo the depth
	logic [addr_w-1:0] idx;
	logic [15:0]       load_data;
	// HLT marker on its way to write-back
	logic [1:0]        halt_pipe;

	assign idx       = ex_q.result[addr_w-1:0];
	assign load_data = mem[idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dmem_depth; i++)
				mem[i] <= '0;
		end else if (ex_q.valid && ex_q.mem_write) begin
			mem[idx] <= ex_q.st_data;
		end
	end

	////////////////////
	// Write-back register
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb        <= '0;
			st        <= '0;
			halt_pipe <= '0;
			hlt       <= 1'b0;
		end else begin
			wb.valid  <= ex_q.valid && ex_q.reg_write;
			wb.rd     <= ex_q.rd;
			wb.data   <= ex_q.mem_read ? load_data : ex_q.result;
			// Store strobe one cycle after the write
			st.valid  <= ex_q.valid && ex_q.mem_write;
			st.addr   <= ex_q.result;
			st.data   <= ex_q.st_data;
			halt_pipe <= {halt_pipe[0], halt_in};
			// Stays up until reset
			hlt       <= hlt || halt_pipe[1];
		end
	end

endmodule

/* source/cpu.sv */
`timescale 1ns/1ps

module cpu #(
	parameter int dmem_depth = 64
) (
	input  logic              clk,
	input  logic              arst_n,
	output logic [15:0]       imem_addr,
	input  logic [15:0]       imem_data,
	output cpu_pkg::wb_port_t wb,
	output cpu_pkg::mem_wr_t  st,
	output logic              hlt
);
	import cpu_pkg::*;

	// Fetch to decode
	logic [15:0] if_pc;
	logic        if_valid;
	// Decode back to fetch
	logic        hold;
	logic        redirect;
	logic [15:0] target;
	logic        halt;
	// Register file read ports
	logic [3:0]  rd_addr0;
	logic [3:0]  rd_addr1;
	logic [15:0] rd_data0;
	logic [15:0] rd_data1;
	// Execute results
	flags_t      flags;
	logic        flag_pending;
	id_ex_t      id_q;
	ex_mem_t     ex_q;

	////////////////////
	// Fetch
	////////////////////

	fetch_stage fetch_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.hold      (hold),
		.redirect  (redirect),
		.target    (target),
		.halt      (halt),
		.imem_addr (imem_addr),
		.if_pc     (if_pc),
		.if_valid  (if_valid)
	);

	////////////////////
	// Decode and registers
	////////////////////

	decode_stage decode_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.instr        (imem_data),
		.if_pc        (if_pc),
		.if_valid     (if_valid),
		.flags        (flags),
		.flag_pending (flag_pending),
		.ex_q         (ex_q),
		.wb_q         (wb),
		.rd_addr0     (rd_addr0),
		.rd_addr1     (rd_addr1),
		.rd_data0     (rd_data0),
		.rd_data1     (rd_data1),
		.hold         (hold),
		.redirect     (redirect),
		.target       (target),
		.halt         (halt),
		.id_q         (id_q)
	);

	// Written from the write-back register
	register_file regs_i (
		.clk      (clk),
		.arst_n   (arst_n),
		.rd_addr0 (rd_addr0),
		.rd_addr1 (rd_addr1),
		.rd_data0 (rd_data0),
		.rd_data1 (rd_data1),
		.wr       (wb)
	);

	////////////////////
	// Execute and memory
	////////////////////

	execute_stage execute_i (
		.clk          (clk),
		.arst_n       (arst_n),
		.id_q         (id_q),
		.flags        (flags),
		.flag_pending (flag_pending),
		.ex_q         (ex_q)
	);

	memory_stage #(
		.dmem_depth (dmem_depth)
	) memory_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.ex_q    (ex_q),
		.wb      (wb),
		.st      (st),
		.halt_in (halt),
		.hlt     (hlt)
	);

endmodule

/* testbench/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
	import cpu_pkg::*;

	localparam int prog_len     = 200;
	localparam int dmem_words   = 64;
	// Four cycles cover a full interlock per instruction plus fill and drain
	localparam int max_cycles   = 4 * prog_len + 100;
	localparam int drain_cycles = 8;

	logic        clk;
	logic        arst_n;
	logic [15:0] imem_addr;
	logic [15:0] imem_data;
	wb_port_t    wb;
	mem_wr_t     st;
	logic        hlt;

	logic [15:0] prog [prog_len];
	int unsigned lcg_state;

	// Expected register writes {rd, data} and stores {addr, data} in program order
	logic [19:0] exp_wb [$];
	logic [31:0] exp_st [$];

	int   mismatches;
	int   failures;
	int   wb_seen;
	int   st_seen;
	int   cycles;
	logic hlt_seen;

	cpu #(
		.dmem_depth (dmem_words)
	) dut_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.wb        (wb),
		.st        (st),
		.hlt       (hlt)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////
	// Stimulus helpers
	////////////////////

	// LCG step returning the upper half of the state
	function automatic logic [15:0] rand_word();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];
	endfunction

	function automatic logic [15:0] rom_word(logic [15:0] addr);
		if (addr < prog_len)
			return prog[addr];
		// HLT words past the program carry the address bits
		return {4'hf, addr[11:0]};
	endfunction

	// Word for the address presented this cycle shows up after the edge
	always @(posedge clk)
		imem_data <= rom_word(imem_addr);

	function automatic logic branch_taken(logic [2:0] c, logic n, logic z, logic v);
		case (c)
			3'd0: return !z;
			3'd1: return z;
			3'd2: return !z && !n;
			3'd3: return n;
			3'd4: return !n;
			3'd5: return n || z;
			3'd6: return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic build_program();
		logic [15:0] w;
		logic [3:0]  op;
		int          room;
		int          off;
		for (int i = 0; i < prog_len - 1; i++) begin
			w  = rand_word();
			op = w[15:12];
			// Only one HLT at the very end
			if (op == 4'd15)
				op = 4'd10;
			w       = rand_word();
			prog[i] = {op, w[11:0]};
			// Half the memory ops use R0 as base so addresses repeat
			if ((op == 4'd8 || op == 4'd9) && w[15])
				prog[i][7:4] = 4'd0;
			// Forward targets only and never past the final HLT
			if (op == 4'd12) begin
				room = prog_len - 2 - i;
				off  = w[2:0];
				if (off > room)
					off = room;
				prog[i][8:0] = 9'(off);
			end
		end
		prog[prog_len-1] = 16'hf000;
	endtask

	////////////////////
	// ISA reference model
	////////////////////

	task automatic run_model();
		logic [15:0] r [16];
		logic [15:0] mem [dmem_words];
		logic [15:0] w;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [15:0] addr;
		logic [15:0] pc;
		logic [15:0] next_pc;
		logic [3:0]  op;
		logic [3:0]  rd;
		logic [3:0]  rt;
		logic        n;
		logic        z;
		logic        v;
		logic        v_new;
		logic        wr;
		logic        done;
		int          sum;
		int          steps;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		for (int i = 0; i < dmem_words; i++)
			mem[i] = '0;
		pc    = '0;
		n     = 1'b0;
		z     = 1'b0;
		v     = 1'b0;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 4 * prog_len) begin
			w       = prog[pc];
			op      = w[15:12];
			rd      = w[11:8];
			rt      = w[3:0];
			a       = r[w[7:4]];
			b       = r[rt];
			// Word address from rs plus signed rt
			addr    = a + {{12{rt[3]}}, rt};
			next_pc = pc + 16'd1;
			wr      = 1'b0;
			v_new   = 1'b0;
			steps++;
			case (op)
				4'd0: begin
					res   = a + b;
					sum   = $signed(a) + $signed(b);
					v_new = (sum > 32767) || (sum < -32768);
					wr    = 1'b1;
				end
				4'd1: begin
					res   = a - b;
					sum   = $signed(a) - $signed(b);
					v_new = (sum > 32767) || (sum < -32768);
					wr    = 1'b1;
				end
				4'd2: begin
					res = a & b;
					wr  = 1'b1;
				end
				4'd3: begin
					res = ~(a | b);
					wr  = 1'b1;
				end
				4'd4: begin
					res = a << rt;
					wr  = 1'b1;
				end
				4'd5: begin
					res = a >> rt;
					wr  = 1'b1;
				end
				4'd6: begin
					// Logical shift with the sign bit filling the vacated top
					res = (a >> rt) | (a[15] ? ~(16'hffff >> rt) : 16'h0);
					wr  = 1'b1;
				end
				4'd8: begin
					res = mem[addr % dmem_words];
					wr  = 1'b1;
				end
				4'd9: begin
					mem[addr % dmem_words] = r[rd];
					exp_st.push_back({addr, r[rd]});
				end
				4'd10: begin
					res = {{8{w[7]}}, w[7:0]};
					wr  = 1'b1;
				end
				4'd11: begin
					res = {w[7:0], r[rd][7:0]};
					wr  = 1'b1;
				end
				4'd12: begin
					if (branch_taken(w[11:9], n, z, v))
						next_pc = pc + 16'd1 + {{7{w[8]}}, w[8:0]};
				end
				4'd15: done = 1'b1;
				default: ;
			endcase
			// Flags only from the ALU and shift ops
			if (op <= 4'd6) begin
				n = res[15];
				z = (res == 16'd0);
				v = v_new;
			end
			if (wr && rd != 4'd0) begin
				r[rd] = res;
				exp_wb.push_back({rd, res});
			end
			pc = next_pc;
		end
		if (!done) begin
			$display("Reference model never reached HLT");
			failures++;
		end
	endtask

	////////////////////
	// Checking
	////////////////////

	task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s, expected %h, got %h",
				$time, what, expected, actual);
			mismatches++;
		end
	endtask

	task automatic check_strobes();
		logic [19:0] exp_w;
		logic [31:0] exp_s;
		if (hlt && (wb.valid || st.valid)) begin
			$display("Strobe seen at time %0t while hlt is high", $time);
			failures++;
		end
		if (wb.valid) begin
			wb_seen++;
			if (wb.rd == 4'd0) begin
				$display("Register write strobe for R0 at time %0t", $time);
				failures++;
			end else if (exp_wb.size() == 0) begin
				$display("Register write strobe at time %0t with none expected", $time);
				failures++;
			end else begin
				exp_w = exp_wb.pop_front();
				compare({12'h0, wb.rd, wb.data}, {12'h0, exp_w},
					$sformatf("register write %0d {rd, data}", wb_seen));
			end
		end
		if (st.valid) begin
			st_seen++;
			if (exp_st.size() == 0) begin
				$display("Store strobe at time %0t with none expected", $time);
				failures++;
			end else begin
				exp_s = exp_st.pop_front();
				compare({st.addr, st.data}, exp_s, $sformatf("store %0d {addr, data}", st_seen));
			end
		end
	endtask

	initial begin
		arst_n     <= 1'b0;
		imem_data  <= '0;
		lcg_state  = 44;
		mismatches = 0;
		failures   = 0;
		wb_seen    = 0;
		st_seen    = 0;
		hlt_seen   = 1'b0;
		build_program();
		run_model();
		$display("Model expects %0d register writes and %0d stores",
			exp_wb.size(), exp_st.size());

		// Outputs quiet while reset is held
		repeat (5) begin
			@(negedge clk);
			compare({wb.valid, st.valid, hlt}, 32'h0, "strobes and hlt in reset");
		end
		@(posedge clk);
		arst_n <= 1'b1;

		@(negedge clk);
		compare(imem_addr, 32'h0, "first fetch address");
		compare({wb.valid, st.valid, hlt}, 32'h0, "strobes and hlt after reset");

		cycles = 0;
		while (!hlt_seen && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
			check_strobes();
			if (hlt) begin
				hlt_seen = 1'b1;
				if (exp_wb.size() != 0 || exp_st.size() != 0) begin
					$display("hlt rose with %0d register writes and %0d stores still expected",
						exp_wb.size(), exp_st.size());
					failures++;
				end
			end
		end

		if (!hlt_seen) begin
			$display("timeout: hlt never rose");
			failures++;
		end else begin
			// Halted core stays silent and hlt stays up
			repeat (drain_cycles) begin
				@(negedge clk);
				check_strobes();
				compare(hlt, 32'h1, "hlt level after halt");
			end
		end
		if (exp_wb.size() != 0 || exp_st.size() != 0) begin
			$display("Run ended with %0d register writes and %0d stores never seen",
				exp_wb.size(), exp_st.size());
			failures++;
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* flist.f */
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/register_file.sv
source/execute_stage.sv
source/memory_stage.sv
source/cpu.sv
testbench/cpu_tb.sv
